//--- hw/mips_consts.svh
// Width, depth and reset constants for the core, included by any file that sizes storage
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// Data path width
`define MIPS_WORD_BITS 32
// Instruction slots in program memory
`define MIPS_MEM_DEPTH 64
// Instruction index width, log2 of the depth
`define MIPS_PC_BITS 6
// Architectural registers
`define MIPS_REG_COUNT 32
// PC after reset and while loading
`define MIPS_RESET_PC 0

`endif

//--- hw/mipsIsaPkg.sv
// Instruction-set types for the MIPS subset, imported by decode, the store and the top level
package mipsIsaPkg;

	// Raw instruction word
	typedef logic [31:0] instrT;

	// rs, rt and rd fields
	typedef logic [4:0] regAddrT;

	// I-type immediate field
	typedef logic [15:0] immT;

	// Primary opcodes in use
	typedef enum logic [5:0] {
		opRType = 6'h00,
		opBeq   = 6'h04,
		opBne   = 6'h05,
		opAddi  = 6'h08,
		opOri   = 6'h0d
	} opcodeT;

	// R-type function field
	typedef enum logic [5:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnNor = 6'h27
	} functT;

endpackage

//--- hw/mipsCorePkg.sv
// Microarchitecture types for data words, the PC and ALU control, imported by the RTL
`include "mips_consts.svh"

package mipsCorePkg;

	// Register and ALU data
	typedef logic [`MIPS_WORD_BITS-1:0] wordT;

	// Instruction index, not a byte address
	typedef logic [`MIPS_PC_BITS-1:0] pcT;

	// ALU operations, chosen in decode
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluNor
	} aluOpT;

endpackage

//--- hw/programMemory.sv
// Instruction store filled by the loader while halted, read combinationally at the fetch PC
`include "mips_consts.svh"

module programMemory
	import mipsIsaPkg::*;
(
	input  logic                     clk,
	input  logic                     progWrite,
	input  logic [`MIPS_PC_BITS-1:0] progAddr,
	input  instrT                    progData,
	input  logic [`MIPS_PC_BITS-1:0] fetchPc,
	output instrT                    instr
);

	// One instruction per slot
	instrT mem [`MIPS_MEM_DEPTH];

	// Loader port, one word per strobe
	always_ff @(posedge clk) begin
		if (progWrite) begin
			mem[progAddr] <= progData;
		end
	end

	// Fetch within the same cycle
	assign instr = mem[fetchPc];

endmodule

//--- hw/registerFile.sv
// 32-entry register file with two read ports, one write port and write-through on reads
`include "mips_consts.svh"

module registerFile
	import mipsIsaPkg::*, mipsCorePkg::*;
(
	input  logic    clk,
	input  logic    arstN,
	input  regAddrT readAddrA,
	input  regAddrT readAddrB,
	output wordT    readDataA,
	output wordT    readDataB,
	input  logic    writeEnable,
	input  regAddrT writeAddr,
	input  wordT    writeData
);

	// No storage behind $zero
	wordT regs [1:`MIPS_REG_COUNT-1];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 1; i < `MIPS_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Zero first, then the word being written this cycle, then storage
	function automatic wordT readPort(regAddrT addr);
		wordT value;
		if (addr == '0) begin
			value = '0;
		end else if (writeEnable && addr == writeAddr) begin
			value = writeData;
		end else begin
			value = regs[addr];
		end
		return value;
	endfunction

	always_comb begin
		readDataA = readPort(readAddrA);
		readDataB = readPort(readAddrB);
	end

endmodule

//--- hw/instructionDecode.sv
// PC and decode step, turns the fetched word into controls and fills the execute register
`include "mips_consts.svh"

module instructionDecode
	import mipsIsaPkg::*, mipsCorePkg::*;
(
	input  logic    clk,
	input  logic    arstN,
	input  logic    run,
	input  instrT   instr,
	output pcT      fetchPc,
	output regAddrT readAddrA,
	output regAddrT readAddrB,
	input  wordT    readDataA,
	input  wordT    readDataB,
	input  logic    branchTaken,
	input  pcT      branchTarget,
	output logic    exValid,
	output pcT      exPc,
	output aluOpT   exAluOp,
	output wordT    exOperandA,
	output wordT    exOperandB,
	output wordT    exImm,
	output logic    exUseImm,
	output logic    exBranchEq,
	output logic    exBranchNe,
	output logic    exWrite,
	output regAddrT exSrcA,
	output regAddrT exSrcB,
	output regAddrT exDest
);

	pcT      pc;
	opcodeT  opcode;
	functT   funct;
	regAddrT rs;
	regAddrT rt;
	regAddrT rd;
	immT     imm;
	aluOpT   aluOp;
	wordT    immExt;
	logic    useImm;
	logic    branchEq;
	logic    branchNe;
	logic    regWrite;
	regAddrT dest;
	logic    issue;

	// Instruction fields
	assign opcode = opcodeT'(instr[31:26]);
	assign funct  = functT'(instr[5:0]);
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];
	assign imm    = instr[15:0];

	assign fetchPc   = pc;
	assign readAddrA = rs;
	assign readAddrB = rt;

	always_comb begin
		// Unknown encodings fall through as no-ops
		aluOp    = aluAdd;
		useImm   = 1'b0;
		branchEq = 1'b0;
		branchNe = 1'b0;
		regWrite = 1'b0;
		dest     = '0;
		// Sign extension covers addi and branch offsets
		immExt   = {{(`MIPS_WORD_BITS-16){imm[15]}}, imm};
		case (opcode)
			opRType: begin
				regWrite = 1'b1;
				dest     = rd;
				case (funct)
					fnAdd:   aluOp = aluAdd;
					fnSub:   aluOp = aluSub;
					fnAnd:   aluOp = aluAnd;
					fnOr:    aluOp = aluOr;
					fnNor:   aluOp = aluNor;
					default: regWrite = 1'b0;
				endcase
			end
			opAddi: begin
				useImm   = 1'b1;
				regWrite = 1'b1;
				dest     = rt;
			end
			opOri: begin
				aluOp    = aluOr;
				useImm   = 1'b1;
				regWrite = 1'b1;
				dest     = rt;
				// Logical immediate is zero extended
				immExt   = {{(`MIPS_WORD_BITS-16){1'b0}}, imm};
			end
			// Branches compare via subtraction, no destination
			opBeq: begin
				aluOp    = aluSub;
				branchEq = 1'b1;
			end
			opBne: begin
				aluOp    = aluSub;
				branchNe = 1'b1;
			end
			default: ;
		endcase
	end

	// Bubble while halted or when a taken branch squashes this slot
	assign issue = run && !branchTaken;

	// PC held at the start address during loading
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= pcT'(`MIPS_RESET_PC);
		end else if (!run) begin
			pc <= pcT'(`MIPS_RESET_PC);
		end else if (branchTaken) begin
			pc <= branchTarget;
		end else begin
			pc <= pc + pcT'(1);
		end
	end

	// Execute register, control half
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			exValid    <= 1'b0;
			exWrite    <= 1'b0;
			exBranchEq <= 1'b0;
			exBranchNe <= 1'b0;
		end else begin
			exValid    <= issue;
			exWrite    <= issue && regWrite;
			exBranchEq <= issue && branchEq;
			exBranchNe <= issue && branchNe;
		end
	end

	// Execute register, payload half
	always_ff @(posedge clk) begin
		exPc       <= pc;
		exAluOp    <= aluOp;
		exOperandA <= readDataA;
		exOperandB <= readDataB;
		exImm      <= immExt;
		exUseImm   <= useImm;
		exSrcA     <= rs;
		exSrcB     <= rt;
		exDest     <= dest;
	end

endmodule

//--- hw/executeUnit.sv
// Execute step, bypasses from the result register, runs the ALU and resolves branches
module executeUnit
	import mipsIsaPkg::*, mipsCorePkg::*;
(
	input  logic    exValid,
	input  pcT      exPc,
	input  aluOpT   exAluOp,
	input  wordT    exOperandA,
	input  wordT    exOperandB,
	input  wordT    exImm,
	input  logic    exUseImm,
	input  logic    exBranchEq,
	input  logic    exBranchNe,
	input  logic    exWrite,
	input  regAddrT exSrcA,
	input  regAddrT exSrcB,
	input  regAddrT exDest,
	input  logic    resValidIn,
	input  logic    resWriteIn,
	input  regAddrT resDestIn,
	input  wordT    resValueIn,
	output logic    branchTaken,
	output pcT      branchTarget,
	output logic    resValid,
	output logic    resWrite,
	output pcT      resPc,
	output regAddrT resDest,
	output wordT    resValue
);

	logic fwdA;
	logic fwdB;
	wordT opA;
	wordT opB;
	wordT aluB;
	wordT aluOut;
	logic equal;

	// Result step write not yet in the register file
	// resWriteIn already excludes $zero
	assign fwdA = resValidIn && resWriteIn && resDestIn == exSrcA;
	assign fwdB = resValidIn && resWriteIn && resDestIn == exSrcB;
	assign opA  = fwdA ? resValueIn : exOperandA;
	assign opB  = fwdB ? resValueIn : exOperandB;

	// Second ALU input
	assign aluB = exUseImm ? exImm : opB;

	always_comb begin
		case (exAluOp)
			aluAdd:  aluOut = opA + aluB;
			aluSub:  aluOut = opA - aluB;
			aluAnd:  aluOut = opA & aluB;
			aluOr:   aluOut = opA | aluB;
			aluNor:  aluOut = ~(opA | aluB);
			default: aluOut = '0;
		endcase
	end

	// beq and bne share the comparator
	assign equal        = opA == opB;
	assign branchTaken  = exValid && ((exBranchEq && equal) || (exBranchNe && !equal));
	// Offset counts instructions from the next slot, wraps at the PC width
	assign branchTarget = exPc + pcT'(1) + pcT'(exImm);

	// Record for the result register
	// For branches this carries rs minus rt
	assign resValid = exValid;
	assign resWrite = exWrite;
	assign resPc    = exPc;
	assign resDest  = exDest;
	assign resValue = aluOut;

endmodule

//--- hw/resultStage.sv
// Result step, holds the retiring instruction, writes the register file and flags retirement
module resultStage
	import mipsIsaPkg::*, mipsCorePkg::*;
(
	input  logic    clk,
	input  logic    arstN,
	input  logic    resValid,
	input  logic    resWrite,
	input  pcT      resPc,
	input  regAddrT resDest,
	input  wordT    resValue,
	output logic    writeEnable,
	output regAddrT writeAddr,
	output wordT    writeData,
	output logic    retireValid,
	output logic    retireWrite,
	output pcT      retirePc,
	output regAddrT retireReg,
	output wordT    ALUResultOut
);

	logic    validQ;
	logic    writeQ;
	pcT      pcQ;
	regAddrT destQ;
	wordT    valueQ;

	// Result register control
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			validQ <= 1'b0;
			writeQ <= 1'b0;
		end else begin
			validQ <= resValid;
			writeQ <= resWrite;
		end
	end

	// Result register payload
	always_ff @(posedge clk) begin
		pcQ    <= resPc;
		destQ  <= resDest;
		valueQ <= resValue;
	end

	// Writes to $zero still retire but never commit
	assign writeEnable = validQ && writeQ && destQ != '0;
	assign writeAddr   = destQ;
	assign writeData   = valueQ;

	// Retire port, also read back by execute for the bypass
	assign retireValid  = validQ;
	assign retireWrite  = writeEnable;
	assign retirePc     = pcQ;
	assign retireReg    = destQ;
	assign ALUResultOut = valueQ;

endmodule

//--- hw/MipsProcessor.sv
// Top level of the three-step MIPS core, loaded through progWrite and started by run
module MipsProcessor
	import mipsIsaPkg::*, mipsCorePkg::*;
(
	input  logic    clk,
	input  logic    arstN,
	input  logic    run,
	input  logic    progWrite,
	input  pcT      progAddr,
	input  instrT   progData,
	output logic    retireValid,
	output logic    retireWrite,
	output pcT      retirePc,
	output regAddrT retireReg,
	output wordT    ALUResultOut
);

	// Fetch and register reads
	pcT      fetchPc;
	instrT   instr;
	regAddrT readAddrA;
	regAddrT readAddrB;
	wordT    readDataA;
	wordT    readDataB;

	// Branch redirect from execute
	logic branchTaken;
	pcT   branchTarget;

	// Execute register
	logic    exValid;
	pcT      exPc;
	aluOpT   exAluOp;
	wordT    exOperandA;
	wordT    exOperandB;
	wordT    exImm;
	logic    exUseImm;
	logic    exBranchEq;
	logic    exBranchNe;
	logic    exWrite;
	regAddrT exSrcA;
	regAddrT exSrcB;
	regAddrT exDest;

	// Next result record
	logic    resValid;
	logic    resWrite;
	pcT      resPc;
	regAddrT resDest;
	wordT    resValue;

	// Register file write
	logic    writeEnable;
	regAddrT writeAddr;
	wordT    writeData;

	programMemory progMem (
		.clk      (clk),
		.progWrite(progWrite),
		.progAddr (progAddr),
		.progData (progData),
		.fetchPc  (fetchPc),
		.instr    (instr)
	);

	registerFile regFile (
		.clk        (clk),
		.arstN      (arstN),
		.readAddrA  (readAddrA),
		.readAddrB  (readAddrB),
		.readDataA  (readDataA),
		.readDataB  (readDataB),
		.writeEnable(writeEnable),
		.writeAddr  (writeAddr),
		.writeData  (writeData)
	);

	instructionDecode decodeStage (
		.clk         (clk),
		.arstN       (arstN),
		.run         (run),
		.instr       (instr),
		.fetchPc     (fetchPc),
		.readAddrA   (readAddrA),
		.readAddrB   (readAddrB),
		.readDataA   (readDataA),
		.readDataB   (readDataB),
		.branchTaken (branchTaken),
		.branchTarget(branchTarget),
		.exValid     (exValid),
		.exPc        (exPc),
		.exAluOp     (exAluOp),
		.exOperandA  (exOperandA),
		.exOperandB  (exOperandB),
		.exImm       (exImm),
		.exUseImm    (exUseImm),
		.exBranchEq  (exBranchEq),
		.exBranchNe  (exBranchNe),
		.exWrite     (exWrite),
		.exSrcA      (exSrcA),
		.exSrcB      (exSrcB),
		.exDest      (exDest)
	);

	// Bypass source is the result register, seen through the retire port
	executeUnit executeStage (
		.exValid     (exValid),
		.exPc        (exPc),
		.exAluOp     (exAluOp),
		.exOperandA  (exOperandA),
		.exOperandB  (exOperandB),
		.exImm       (exImm),
		.exUseImm    (exUseImm),
		.exBranchEq  (exBranchEq),
		.exBranchNe  (exBranchNe),
		.exWrite     (exWrite),
		.exSrcA      (exSrcA),
		.exSrcB      (exSrcB),
		.exDest      (exDest),
		.resValidIn  (retireValid),
		.resWriteIn  (retireWrite),
		.resDestIn   (retireReg),
		.resValueIn  (ALUResultOut),
		.branchTaken (branchTaken),
		.branchTarget(branchTarget),
		.resValid    (resValid),
		.resWrite    (resWrite),
		.resPc       (resPc),
		.resDest     (resDest),
		.resValue    (resValue)
	);

	resultStage retireStage (
		.clk         (clk),
		.arstN       (arstN),
		.resValid    (resValid),
		.resWrite    (resWrite),
		.resPc       (resPc),
		.resDest     (resDest),
		.resValue    (resValue),
		.writeEnable (writeEnable),
		.writeAddr   (writeAddr),
		.writeData   (writeData),
		.retireValid (retireValid),
		.retireWrite (retireWrite),
		.retirePc    (retirePc),
		.retireReg   (retireReg),
		.ALUResultOut(ALUResultOut)
	);

endmodule

//--- testbench/clockGen.sv
// Testbench clock and reset source, 40 ns period, reset low for 4 cycles at start and on request
module clockGen (
	output logic clk,
	input  logic resetReq,
	output logic arstN
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Reset released 2 ns after the 4th edge, same offset as the stimulus
	initial begin
		arstN = 1'b0;
		forever begin
			repeat (4) @(posedge clk);
			#2;
			arstN = 1'b1;
			@(posedge clk);
			while (!resetReq) @(posedge clk);
			#2;
			arstN = 1'b0;
		end
	end

endmodule

//--- testbench/mips_assertions.sv
// Retire port assertions, attached to the core by bind at the end of this file
module mipsAssertions
	import mipsIsaPkg::*;
(
	input logic    clk,
	input logic    arstN,
	input logic    run,
	input logic    retireValid,
	input logic    retireWrite,
	input regAddrT retireReg
);

	timeunit 1ns;
	timeprecision 100ps;

	// Nothing retires under reset
	quietInReset: assert property (@(posedge clk) !arstN |-> !retireValid)
		else $error("retireValid high while arstN is low");

	// $zero is never committed
	noZeroWrite: assert property (@(posedge clk) disable iff (!arstN)
		retireWrite |-> retireReg != '0)
		else $error("retireWrite with retireReg zero");

	// Two pipeline steps to fill after start
	startLatency: assert property (@(posedge clk) disable iff (!arstN)
		$rose(run) |-> !retireValid ##1 !retireValid)
		else $error("retireValid within two cycles of run rising");

endmodule

bind MipsProcessor mipsAssertions retireChecks (
	.clk        (clk),
	.arstN      (arstN),
	.run        (run),
	.retireValid(retireValid),
	.retireWrite(retireWrite),
	.retireReg  (retireReg)
);

//--- testbench/mipsTb.sv
// Testbench for the MIPS core, loads random programs and checks retirements against a model
`include "mips_consts.svh"

module mipsTb
	import mipsIsaPkg::*, mipsCorePkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NumPrograms   = 8;
	localparam int MaxInstrs     = 40;
	localparam int TimeoutCycles = NumPrograms * (MaxInstrs + 10) * 2;

	// Instruction kinds for generator and model
	localparam int KindAdd  = 0;
	localparam int KindSub  = 1;
	localparam int KindAnd  = 2;
	localparam int KindOr   = 3;
	localparam int KindNor  = 4;
	localparam int KindAddi = 5;
	localparam int KindOri  = 6;
	localparam int KindBeq  = 7;
	localparam int KindBne  = 8;

	logic    clk;
	logic    arstN;
	logic    resetReq;
	logic    run;
	logic    progWrite;
	pcT      progAddr;
	instrT   progData;
	logic    retireValid;
	logic    retireWrite;
	pcT      retirePc;
	regAddrT retireReg;
	wordT    ALUResultOut;

	// Current program, halt branch at index progLen
	int      progLen;
	int      kinds [MaxInstrs];
	regAddrT rsF [MaxInstrs];
	regAddrT rtF [MaxInstrs];
	regAddrT rdF [MaxInstrs];
	immT     imms [MaxInstrs];
	instrT   words [MaxInstrs + 1];
	regAddrT lastDest0;
	regAddrT lastDest1;

	// Expected retirements in program order
	pcT      expPc [$];
	logic    expWrite [$];
	regAddrT expReg [$];
	wordT    expValue [$];

	int      cycleCount;
	int      runCycle;
	int      errorCount;
	int      checkCount;
	int      retireCount;
	int      totalRetired;
	bit      running;
	bit      haltSeen;
	bit      firstSeen;

	clockGen clockSrc (
		.clk     (clk),
		.resetReq(resetReq),
		.arstN   (arstN)
	);

	MipsProcessor DUT (
		.clk         (clk),
		.arstN       (arstN),
		.run         (run),
		.progWrite   (progWrite),
		.progAddr    (progAddr),
		.progData    (progData),
		.retireValid (retireValid),
		.retireWrite (retireWrite),
		.retirePc    (retirePc),
		.retireReg   (retireReg),
		.ALUResultOut(ALUResultOut)
	);

	task automatic checkWord(string name, wordT got, wordT exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("ERROR t=%0t %s got=%h exp=%h", $time, name, got, exp);
		end
	endtask

	task automatic checkPc(string name, pcT got, pcT exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("ERROR t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
		end
	endtask

	task automatic checkReg(string name, regAddrT got, regAddrT exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("ERROR t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
		end
	endtask

	task automatic checkFlag(string name, logic got, logic exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("ERROR t=%0t %s got=%b exp=%b", $time, name, got, exp);
		end
	endtask

	// Half the sources reuse one of the last two destinations
	function automatic regAddrT pickReg();
		int choice;
		regAddrT r;
		choice = int'($urandom_range(3, 0));
		if (choice == 0) begin
			r = lastDest0;
		end else if (choice == 1) begin
			r = lastDest1;
		end else begin
			r = regAddrT'($urandom_range(31, 0));
		end
		return r;
	endfunction

	function automatic instrT encode(int kind, regAddrT rs, regAddrT rt, regAddrT rd, immT imm);
		instrT w;
		case (kind)
			KindAdd:  w = {opRType, rs, rt, rd, 5'd0, fnAdd};
			KindSub:  w = {opRType, rs, rt, rd, 5'd0, fnSub};
			KindAnd:  w = {opRType, rs, rt, rd, 5'd0, fnAnd};
			KindOr:   w = {opRType, rs, rt, rd, 5'd0, fnOr};
			KindNor:  w = {opRType, rs, rt, rd, 5'd0, fnNor};
			KindAddi: w = {opAddi, rs, rt, imm};
			KindOri:  w = {opOri, rs, rt, imm};
			KindBeq:  w = {opBeq, rs, rt, imm};
			default:  w = {opBne, rs, rt, imm};
		endcase
		return w;
	endfunction

	task automatic buildProgram();
		int maxOff;
		progLen   = int'($urandom_range(MaxInstrs, 12));
		lastDest0 = regAddrT'($urandom_range(31, 0));
		lastDest1 = regAddrT'($urandom_range(31, 0));
		for (int i = 0; i < progLen; i++) begin
			kinds[i] = int'($urandom_range(KindBne, KindAdd));
			rsF[i]   = pickReg();
			rtF[i]   = pickReg();
			rdF[i]   = regAddrT'($urandom_range(31, 0));
			imms[i]  = immT'($urandom_range(16'hffff, 0));
			if (kinds[i] >= KindBeq) begin
				// Forward only, never past the halt
				maxOff  = (progLen - 1 - i < 3) ? progLen - 1 - i : 3;
				imms[i] = immT'($urandom_range(maxOff, 0));
				// Same register on both sides makes beq taken
				if ($urandom_range(3, 0) == 0) begin
					rtF[i] = rsF[i];
				end
			end else begin
				lastDest1 = lastDest0;
				lastDest0 = (kinds[i] <= KindNor) ? rdF[i] : rtF[i];
			end
			words[i] = encode(kinds[i], rsF[i], rtF[i], rdF[i], imms[i]);
		end
		// Halt, beq $zero to itself
		words[progLen] = encode(KindBeq, 5'd0, 5'd0, 5'd0, 16'hffff);
	endtask

	task automatic pushExpected(pcT pc, logic wr, regAddrT dest, wordT value);
		expPc.push_back(pc);
		expWrite.push_back(wr);
		expReg.push_back(dest);
		expValue.push_back(value);
	endtask

	// Instruction-level model, one retirement per executed instruction
	task automatic runModel();
		wordT    regs [`MIPS_REG_COUNT];
		int      pc;
		wordT    a;
		wordT    b;
		wordT    v;
		regAddrT dest;
		logic    isBranch;
		logic    taken;
		foreach (regs[r]) begin
			regs[r] = '0;
		end
		expPc.delete();
		expWrite.delete();
		expReg.delete();
		expValue.delete();
		pc = 0;
		while (pc < progLen) begin
			a        = regs[rsF[pc]];
			b        = regs[rtF[pc]];
			dest     = '0;
			isBranch = 1'b0;
			taken    = 1'b0;
			case (kinds[pc])
				KindAdd: begin
					v    = a + b;
					dest = rdF[pc];
				end
				KindSub: begin
					v    = a - b;
					dest = rdF[pc];
				end
				KindAnd: begin
					v    = a & b;
					dest = rdF[pc];
				end
				KindOr: begin
					v    = a | b;
					dest = rdF[pc];
				end
				KindNor: begin
					v    = ~(a | b);
					dest = rdF[pc];
				end
				KindAddi: begin
					v    = a + {{16{imms[pc][15]}}, imms[pc]};
					dest = rtF[pc];
				end
				KindOri: begin
					v    = a | {16'h0000, imms[pc]};
					dest = rtF[pc];
				end
				KindBeq: begin
					v        = a - b;
					isBranch = 1'b1;
					taken    = (a == b);
				end
				default: begin
					v        = a - b;
					isBranch = 1'b1;
					taken    = (a != b);
				end
			endcase
			pushExpected(pcT'(pc), !isBranch && dest != '0, dest, v);
			if (!isBranch && dest != '0) begin
				regs[dest] = v;
			end
			pc = taken ? pc + 1 + int'(imms[pc]) : pc + 1;
		end
		pushExpected(pcT'(progLen), 1'b0, '0, '0);
	endtask

	task automatic loadProgram();
		for (int i = 0; i <= progLen; i++) begin
			@(posedge clk);
			#2;
			progWrite = 1'b1;
			progAddr  = pcT'(i);
			progData  = words[i];
		end
		@(posedge clk);
		#2;
		progWrite = 1'b0;
	endtask

	// Reset hits a running core, run drops once arstN is low
	task automatic requestReset();
		@(posedge clk);
		#2;
		resetReq = 1'b1;
		wait (arstN === 1'b0);
		resetReq = 1'b0;
		run      = 1'b0;
		running  = 1'b0;
		wait (arstN === 1'b1);
	endtask

	// Cycle counter and timeout
	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= TimeoutCycles) begin
			$display("Timeout after %0d cycles, halt branch not reached", cycleCount);
			$display("Checks failed");
			$finish;
		end
	end

	// Retirement monitor, sampled mid-cycle
	always @(negedge clk) begin
		if (arstN && retireValid && !haltSeen) begin
			if (!running) begin
				errorCount++;
				$display("Instruction retired at t=%0t while the program was loading", $time);
			end else if (expPc.size() == 0) begin
				errorCount++;
				$display("Instruction at PC %0d retired with no expected entry", retirePc);
			end else begin
				if (!firstSeen && cycleCount - runCycle != 2) begin
					errorCount++;
					$display("First retirement came %0d cycles after run, not 2",
						cycleCount - runCycle);
				end
				firstSeen = 1'b1;
				checkPc("retirePc", retirePc, expPc.pop_front());
				checkFlag("retireWrite", retireWrite, expWrite.pop_front());
				checkReg("retireReg", retireReg, expReg.pop_front());
				checkWord("ALUResultOut", ALUResultOut, expValue.pop_front());
				retireCount++;
				if (retirePc == pcT'(progLen)) begin
					haltSeen = 1'b1;
				end
			end
		end
	end

	initial begin
		int expectedCount;
		run        = 1'b0;
		progWrite  = 1'b0;
		progAddr   = '0;
		progData   = '0;
		resetReq   = 1'b0;
		running    = 1'b0;
		haltSeen   = 1'b0;
		firstSeen  = 1'b0;
		cycleCount = 0;
		errorCount = 0;
		checkCount = 0;
		void'($urandom(3571));
		wait (arstN === 1'b1);
		for (int prog = 0; prog < NumPrograms; prog++) begin
			haltSeen    = 1'b0;
			firstSeen   = 1'b0;
			retireCount = 0;
			buildProgram();
			runModel();
			expectedCount = expPc.size();
			loadProgram();
			// Start in the cycle right after the last write
			run        = 1'b1;
			running    = 1'b1;
			runCycle   = cycleCount;
			while (!haltSeen) @(negedge clk);
			// Halt branch keeps retiring until reset clears the pipeline
			requestReset();
			if (retireCount != expectedCount) begin
				errorCount++;
				$display("Program %0d retired %0d instructions, model expects %0d",
					prog, retireCount, expectedCount);
			end
			totalRetired += retireCount;
		end
		$display("Programs %0d, retirements %0d, checks %0d, errors %0d",
			NumPrograms, totalRetired, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- build.f
+incdir+hw
hw/mipsIsaPkg.sv
hw/mipsCorePkg.sv
hw/programMemory.sv
hw/registerFile.sv
hw/instructionDecode.sv
hw/executeUnit.sv
hw/resultStage.sv
hw/MipsProcessor.sv
testbench/clockGen.sv
testbench/mips_assertions.sv
testbench/mipsTb.sv

//--- run.sh
#!/bin/sh
# Build the core and its testbench with Verilator, run once, look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module mipsTb -o mipsSim

# A failing assertion may end the run early, so the output decides
simOut=$(./obj_dir/mipsSim) || true
printf '%s\n' "$simOut"

printf '%s\n' "$simOut" | grep -qx "All checks passed"
